// ==== gb_dl_params.svh ====
// Download front end constants: bus widths, host file-type codes, boot checksums, palette default
`ifndef GB_DL_PARAMS_SVH
`define GB_DL_PARAMS_SVH

//////////////////////////////////////////////////////////////////////
// Host protocol widths
//////////////////////////////////////////////////////////////////////

`define DL_WORD_W       16
`define DL_ADDR_W       25
`define FILETYPE_W      8
`define CHECKSUM_W      18
`define PALETTE_W       128
`define GG_CODE_W       129

//////////////////////////////////////////////////////////////////////
// File-type codes sent by the host
//////////////////////////////////////////////////////////////////////

// Cart matches on the low six bits only
`define FT_CART_LO      6'h01
`define FT_CART_ALT     8'h80
`define FT_MEGADUCK     8'h81
`define FT_PALETTE      8'h03
`define FT_BORDER       8'h02
`define FT_CGB_BOOT     8'h04
`define FT_DMG_BOOT     8'h05
`define FT_SGB_BOOT     8'h06
`define FT_CHEAT        8'hFF

// Byte sums of known colour boot ROM images
`define CGB_BOOT_SUM_MISTER     18'h2CE10
`define CGB_BOOT_SUM_ORIGINAL   18'h2F3EA

// Four 24-bit greens, low 32 bits unused
`define PALETTE_DEFAULT 128'h828214517356305A5F1A3B4900000000

`endif

// ==== gb_dl_pkg.sv ====
// Shared types for the download front end: word, address and payload vectors and download kinds
`include "gb_dl_params.svh"

package gb_dl_pkg;

	//////////////////////////////////////////////////////////////////////
	// Host stream vectors
	//////////////////////////////////////////////////////////////////////

	typedef logic [`DL_WORD_W-1:0]  dl_word_t;
	typedef logic [`DL_ADDR_W-1:0]  dl_addr_t;
	typedef logic [`FILETYPE_W-1:0] filetype_t;

	// Class of the download in progress
	typedef enum logic [3:0] {
		DL_NONE,
		DL_CART,
		DL_MEGADUCK,
		DL_PALETTE,
		DL_BORDER,
		DL_CGB_BOOT,
		DL_DMG_BOOT,
		DL_SGB_BOOT,
		DL_CHEAT
	} dl_kind_e;

	//////////////////////////////////////////////////////////////////////
	// Payload vectors
	//////////////////////////////////////////////////////////////////////

	// Byte sum of a colour boot ROM, wraps at 2^18
	typedef logic [`CHECKSUM_W-1:0] checksum_t;

	// pal1..pal4 in the top 96 bits
	typedef logic [`PALETTE_W-1:0]  palette_t;

	// {strobe, flags, address, compare, replace}
	typedef logic [`GG_CODE_W-1:0]  gg_code_t;

endpackage

// ==== dl_classify.sv ====
// Classify stage: registers the host stream and tags each word with its download kind
`timescale 1ns/1ns
`include "gb_dl_params.svh"

module dl_classify (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  logic                  ioctl_download,
	input  logic                  ioctl_wr,
	input  gb_dl_pkg::dl_addr_t   ioctl_addr,
	input  gb_dl_pkg::dl_word_t   ioctl_dout,
	input  gb_dl_pkg::filetype_t  filetype,
	output gb_dl_pkg::dl_kind_e   dl_kind,
	output logic                  dl_wr,
	output gb_dl_pkg::dl_addr_t   dl_addr,
	output gb_dl_pkg::dl_word_t   dl_data,
	output logic                  dl_start,
	output logic                  cart_download,
	output logic                  boot_download
);

	import gb_dl_pkg::*;

	dl_kind_e kind_next;

	//////////////////////////////////////////////////////////////////////
	// File-type decode
	//////////////////////////////////////////////////////////////////////

	// MegaDuck before cart since its code also matches the cart rule
	always_comb begin
		kind_next = DL_NONE;
		if (ioctl_download) begin
			if (filetype == `FT_CHEAT)
				kind_next = DL_CHEAT;
			else if (filetype == `FT_MEGADUCK)
				kind_next = DL_MEGADUCK;
			else if (filetype[5:0] == `FT_CART_LO || filetype == `FT_CART_ALT)
				kind_next = DL_CART;
			else if (filetype == `FT_PALETTE)
				kind_next = DL_PALETTE;
			else if (filetype == `FT_BORDER)
				kind_next = DL_BORDER;
			else if (filetype == `FT_CGB_BOOT)
				kind_next = DL_CGB_BOOT;
			else if (filetype == `FT_DMG_BOOT)
				kind_next = DL_DMG_BOOT;
			else if (filetype == `FT_SGB_BOOT)
				kind_next = DL_SGB_BOOT;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Registered stream
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			dl_kind  <= DL_NONE;
			dl_wr    <= 1'b0;
			dl_start <= 1'b0;
		end else begin
			dl_kind  <= kind_next;
			dl_wr    <= ioctl_wr;
			// New download, or the host switched type without dropping the level
			dl_start <= (kind_next != DL_NONE) && (kind_next != dl_kind);
		end
	end

	// Payload follows the control by one cycle like everything else
	always_ff @(posedge clk_sys) begin
		dl_addr <= ioctl_addr;
		dl_data <= ioctl_dout;
	end

	// MegaDuck images load through the cart path too
	assign cart_download = (dl_kind == DL_CART) || (dl_kind == DL_MEGADUCK);
	assign boot_download = (dl_kind == DL_CGB_BOOT) || (dl_kind == DL_DMG_BOOT) ||
	                       (dl_kind == DL_SGB_BOOT);

endmodule

// ==== boot_check.sv ====
// Boot ROM check stage: colour boot checksum, custom boot flags and the derived feature flags
`timescale 1ns/1ns
`include "gb_dl_params.svh"

module boot_check (
	input  logic                 clk_sys,
	input  logic                 reset,
	input  gb_dl_pkg::dl_kind_e  dl_kind,
	input  logic                 dl_wr,
	input  gb_dl_pkg::dl_word_t  dl_data,
	input  logic                 dl_start,
	input  logic                 is_gbc,
	output logic                 fastboot_available,
	output logic                 boot_gba_available,
	output logic                 real_cgb_boot
);

	import gb_dl_pkg::*;

	checksum_t checksum;
	checksum_t byte_sum;
	logic      custom_cgb;
	logic      custom_dmg;
	logic      sum_mister;
	logic      sum_original;
	logic      cgb_word;

	//////////////////////////////////////////////////////////////////////
	// Colour boot ROM checksum
	//////////////////////////////////////////////////////////////////////

	assign cgb_word = (dl_kind == DL_CGB_BOOT) && dl_wr;

	// Both bytes of the word, zero extended
	assign byte_sum = checksum_t'(dl_data[15:8]) + checksum_t'(dl_data[7:0]);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			checksum <= '0;
		end else if (dl_start && dl_kind == DL_CGB_BOOT) begin
			// Restart the sum, keeping a word that arrives on the first cycle
			checksum <= cgb_word ? byte_sum : '0;
		end else if (cgb_word) begin
			checksum <= checksum + byte_sum;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Custom boot ROM flags
	//////////////////////////////////////////////////////////////////////

	// Sticky until reset, any written word marks the ROM as replaced
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			custom_cgb <= 1'b0;
			custom_dmg <= 1'b0;
		end else begin
			if (cgb_word)
				custom_cgb <= 1'b1;
			if (dl_kind == DL_DMG_BOOT && dl_wr)
				custom_dmg <= 1'b1;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Feature flags
	//////////////////////////////////////////////////////////////////////

	assign sum_mister   = (checksum == `CGB_BOOT_SUM_MISTER);
	assign sum_original = (checksum == `CGB_BOOT_SUM_ORIGINAL);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			fastboot_available <= 1'b1;
			boot_gba_available <= 1'b1;
			real_cgb_boot      <= 1'b0;
		end else begin
			real_cgb_boot      <= sum_original;
			// GBA mode needs the stock ROM, a known ROM image, or no custom ROM at all
			boot_gba_available <= !custom_cgb || sum_original || sum_mister;
			// Fast boot only works with the known colour ROM image, never with a custom DMG ROM
			fastboot_available <= !((is_gbc && custom_cgb && !sum_mister) ||
			                        (!is_gbc && custom_dmg));
		end
	end

endmodule

// ==== config_capture.sv ====
// Config capture stage: monochrome palette shift register and cheat code assembler
`timescale 1ns/1ns
`include "gb_dl_params.svh"

module config_capture (
	input  logic                     clk_sys,
	input  logic                     reset,
	input  gb_dl_pkg::dl_kind_e      dl_kind,
	input  logic                     dl_wr,
	input  gb_dl_pkg::dl_addr_t      dl_addr,
	input  gb_dl_pkg::dl_word_t      dl_data,
	output gb_dl_pkg::palette_t      palette,
	output logic [`GG_CODE_W-2:0]    gg_code,
	output logic                     gg_strobe,
	output logic                     gg_reset
);

	import gb_dl_pkg::*;

	gg_code_t gg_reg;
	logic     pal_word;
	logic     cheat_word;

	assign pal_word   = (dl_kind == DL_PALETTE) && dl_wr;
	assign cheat_word = (dl_kind == DL_CHEAT) && dl_wr;

	//////////////////////////////////////////////////////////////////////
	// Palette
	//////////////////////////////////////////////////////////////////////

	// Host sends big endian colours, so swap the bytes of each word
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			palette <= `PALETTE_DEFAULT;
		end else if (pal_word) begin
			palette <= {palette[`PALETTE_W-17:0], dl_data[7:0], dl_data[15:8]};
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Cheat code assembly
	//////////////////////////////////////////////////////////////////////

	// Eight words per code, placed by byte offset within a 16-byte record
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			gg_reg <= '0;
		end else begin
			gg_reg[128] <= 1'b0;
			if (cheat_word) begin
				case (dl_addr[3:0])
					4'd0:  gg_reg[111:96]  <= dl_data;
					4'd2:  gg_reg[127:112] <= dl_data;
					4'd4:  gg_reg[79:64]   <= dl_data;
					4'd6:  gg_reg[95:80]   <= dl_data;
					4'd8:  gg_reg[47:32]   <= dl_data;
					4'd10: gg_reg[63:48]   <= dl_data;
					4'd12: gg_reg[15:0]    <= dl_data;
					4'd14: begin
						gg_reg[31:16] <= dl_data;
						// Last word, hand the whole code over
						gg_reg[128]   <= 1'b1;
					end
					default: ;
				endcase
			end
		end
	end

	assign gg_code   = gg_reg[`GG_CODE_W-2:0];
	assign gg_strobe = gg_reg[`GG_CODE_W-1];

	//////////////////////////////////////////////////////////////////////
	// Cheat list reset
	//////////////////////////////////////////////////////////////////////

	// A new cheat file starts at address 0; a cart or palette download wipes the list
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			gg_reset <= 1'b0;
		end else begin
			gg_reset <= (cheat_word && dl_addr == '0) ||
			            (dl_kind == DL_CART) ||
			            (dl_kind == DL_MEGADUCK) ||
			            (dl_kind == DL_PALETTE);
		end
	end

endmodule

// ==== gb_dl_top.sv ====
// Download front end top: classify stage feeding the boot check and config capture stages
`timescale 1ns/1ns
`include "gb_dl_params.svh"

module gb_dl_top (
	input  logic                     clk_sys,
	input  logic                     reset,
	input  logic                     ioctl_download,
	input  logic                     ioctl_wr,
	input  gb_dl_pkg::dl_addr_t      ioctl_addr,
	input  gb_dl_pkg::dl_word_t      ioctl_dout,
	input  gb_dl_pkg::filetype_t     filetype,
	input  logic                     is_gbc,
	output logic                     cart_download,
	output logic                     boot_download,
	output logic                     fastboot_available,
	output logic                     boot_gba_available,
	output logic                     real_cgb_boot,
	output gb_dl_pkg::palette_t      palette,
	output logic [`GG_CODE_W-2:0]    gg_code,
	output logic                     gg_strobe,
	output logic                     gg_reset
);

	import gb_dl_pkg::*;

	// Registered stream shared by both payload stages
	dl_kind_e dl_kind;
	logic     dl_wr;
	dl_addr_t dl_addr;
	dl_word_t dl_data;
	logic     dl_start;

	//////////////////////////////////////////////////////////////////////
	// Stage 1
	//////////////////////////////////////////////////////////////////////

	dl_classify u_classify (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.ioctl_download (ioctl_download),
		.ioctl_wr       (ioctl_wr),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout),
		.filetype       (filetype),
		.dl_kind        (dl_kind),
		.dl_wr          (dl_wr),
		.dl_addr        (dl_addr),
		.dl_data        (dl_data),
		.dl_start       (dl_start),
		.cart_download  (cart_download),
		.boot_download  (boot_download)
	);

	//////////////////////////////////////////////////////////////////////
	// Stage 2, side by side
	//////////////////////////////////////////////////////////////////////

	boot_check u_boot_check (
		.clk_sys            (clk_sys),
		.reset              (reset),
		.dl_kind            (dl_kind),
		.dl_wr              (dl_wr),
		.dl_data            (dl_data),
		.dl_start           (dl_start),
		.is_gbc             (is_gbc),
		.fastboot_available (fastboot_available),
		.boot_gba_available (boot_gba_available),
		.real_cgb_boot      (real_cgb_boot)
	);

	config_capture u_config_capture (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.dl_kind   (dl_kind),
		.dl_wr     (dl_wr),
		.dl_addr   (dl_addr),
		.dl_data   (dl_data),
		.palette   (palette),
		.gg_code   (gg_code),
		.gg_strobe (gg_strobe),
		.gg_reset  (gg_reset)
	);

endmodule

// ==== tb_clock.sv ====
// Testbench clock and reset source, 10 ns clock with reset held for the first three cycles
`timescale 1ns/1ns

module tb_clock (
	input  logic reset_req,
	output logic clk_sys,
	output logic reset
);

	logic power_on = 1'b1;

	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	// Release on a falling edge, away from the DUT's sampling edge
	initial begin
		repeat (3) @(posedge clk_sys);
		@(negedge clk_sys);
		power_on = 1'b0;
	end

	assign reset = power_on || reset_req;

endmodule

// ==== tb_gb_dl.sv ====
// Testbench top for the download front end: host downloads, output model and checks
`timescale 1ns/1ns
`include "gb_dl_params.svh"

module tb_gb_dl;

	import gb_dl_pkg::*;

	localparam int RAND_WORDS    = 8;
	localparam int WORD_CYCLES   = 2;
	localparam int DL_OVERHEAD   = 6;
	// 2^18 / 510 full words plus one remainder word
	localparam int MAX_PAD_WORDS = 516;
	localparam int SHORT_DL      = RAND_WORDS * WORD_CYCLES + DL_OVERHEAD;
	localparam int LONG_DL       = (RAND_WORDS + MAX_PAD_WORDS) * WORD_CYCLES + DL_OVERHEAD;
	localparam int TEST_CYCLES   = 20 + 6 * SHORT_DL + 2 * LONG_DL;
	localparam int CYCLE_LIMIT   = TEST_CYCLES * 12 / 10;

	logic                  clk_sys;
	logic                  reset;
	logic                  reset_req;
	logic                  ioctl_download;
	logic                  ioctl_wr;
	dl_addr_t              ioctl_addr;
	dl_word_t              ioctl_dout;
	filetype_t             filetype;
	logic                  is_gbc;
	logic                  cart_download;
	logic                  boot_download;
	logic                  fastboot_available;
	logic                  boot_gba_available;
	logic                  real_cgb_boot;
	palette_t              palette;
	logic [`GG_CODE_W-2:0] gg_code;
	logic                  gg_strobe;
	logic                  gg_reset;

	logic [31:0] lfsr_state;
	dl_word_t    tx_words[$];
	int          check_count = 0;
	int          error_count = 0;
	int          errors_at_start = 0;
	int          test_count = 0;
	int          tests_failed = 0;
	int          cycle_count = 0;
	int          cart_cycles = 0;
	int          boot_cycles = 0;
	int          greset_cycles = 0;
	int          strobe_cycles = 0;

	// Expected output levels, delayed as the DUT delays them
	logic       cart_type;
	logic       boot_type;
	logic       cheat_wr;
	logic       cart_d1;
	logic       boot_d1;
	logic [1:0] wipe_hist;
	logic [1:0] first_cheat_hist;
	logic [1:0] last_cheat_hist;

	tb_clock clock_gen (
		.reset_req (reset_req),
		.clk_sys   (clk_sys),
		.reset     (reset)
	);

	gb_dl_top dut (.*);

	//////////////////////////////////////////////////////////////////////
	// Output model and per-cycle checks
	//////////////////////////////////////////////////////////////////////

	assign cart_type = filetype[5:0] == `FT_CART_LO || filetype == `FT_CART_ALT;
	assign boot_type = filetype == `FT_CGB_BOOT || filetype == `FT_DMG_BOOT ||
	                   filetype == `FT_SGB_BOOT;
	assign cheat_wr  = ioctl_download && ioctl_wr && filetype == `FT_CHEAT;

	always @(posedge clk_sys) begin
		if (reset) begin
			cart_d1          <= 1'b0;
			boot_d1          <= 1'b0;
			wipe_hist        <= '0;
			first_cheat_hist <= '0;
			last_cheat_hist  <= '0;
		end else begin
			cart_d1          <= ioctl_download && cart_type;
			boot_d1          <= ioctl_download && boot_type;
			wipe_hist        <= {wipe_hist[0],
			                     ioctl_download && (cart_type || filetype == `FT_PALETTE)};
			first_cheat_hist <= {first_cheat_hist[0], cheat_wr && ioctl_addr == '0};
			last_cheat_hist  <= {last_cheat_hist[0], cheat_wr && ioctl_addr[3:0] == 4'd14};
		end
	end

	always @(negedge clk_sys) begin
		if (reset === 1'b0) begin
			check_bit("cart_download", cart_download, cart_d1);
			check_bit("boot_download", boot_download, boot_d1);
			check_bit("gg_reset", gg_reset, wipe_hist[1] || first_cheat_hist[1]);
			check_bit("gg_strobe", gg_strobe, last_cheat_hist[1]);
			if (cart_download)
				cart_cycles++;
			if (boot_download)
				boot_cycles++;
			if (gg_reset)
				greset_cycles++;
			if (gg_strobe)
				strobe_cycles++;
		end
	end

	assert property (@(posedge clk_sys) disable iff (reset) gg_strobe |=> !gg_strobe)
		else begin
			error_count++;
			$display("gg_strobe stayed high for more than one cycle");
		end

	//////////////////////////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////////////////////////

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		logic fb;
		fb = s[31] ^ s[21] ^ s[1] ^ s[0];
		return {s[30:0], fb};
	endfunction

	task automatic draw_word(output dl_word_t w);
		w = '0;
		repeat (16) begin
			lfsr_state = lfsr_next(lfsr_state);
			w = {w[14:0], lfsr_state[0]};
		end
	endtask

	task automatic fill_random(input int count);
		dl_word_t w;
		tx_words.delete();
		repeat (count) begin
			draw_word(w);
			tx_words.push_back(w);
		end
	endtask

	function automatic checksum_t word_byte_sum(input dl_word_t w);
		return checksum_t'(w[15:8]) + checksum_t'(w[7:0]);
	endfunction

	task automatic check_bit(input string name, input logic got, input logic expected);
		check_count++;
		assert (got === expected) else begin
			error_count++;
			$display("FAIL %s: got %h, expected %h", name, got, expected);
		end
	endtask

	task automatic check_vec(input string name, input logic [127:0] got,
	                         input logic [127:0] expected);
		check_count++;
		assert (got === expected) else begin
			error_count++;
			$display("FAIL %s: got %h, expected %h", name, got, expected);
		end
	endtask

	task automatic expect_true(input logic cond, input string what);
		check_count++;
		assert (cond) else begin
			error_count++;
			$display("Error: %s", what);
		end
	endtask

	task automatic check_boot_flags(input logic fast, input logic gba, input logic real_boot);
		check_bit("fastboot_available", fastboot_available, fast);
		check_bit("boot_gba_available", boot_gba_available, gba);
		check_bit("real_cgb_boot", real_cgb_boot, real_boot);
	endtask

	// One download of tx_words at byte addresses 0, 2, 4 with an idle cycle between writes
	task automatic send_download(input filetype_t ft);
		@(negedge clk_sys);
		filetype       = ft;
		ioctl_download = 1'b1;
		foreach (tx_words[i]) begin
			@(negedge clk_sys);
			ioctl_wr   = 1'b1;
			ioctl_addr = dl_addr_t'(2 * i);
			ioctl_dout = tx_words[i];
			@(negedge clk_sys);
			ioctl_wr   = 1'b0;
		end
		@(negedge clk_sys);
		ioctl_download = 1'b0;
		repeat (4) @(negedge clk_sys);
	endtask

	// Random head, then words that bring the byte sum to the target modulo 2^18
	task automatic build_padded_image(input checksum_t target);
		checksum_t need;
		fill_random(RAND_WORDS);
		need = target;
		foreach (tx_words[i]) begin
			need = need - word_byte_sum(tx_words[i]);
		end
		while (need >= 18'd510) begin
			tx_words.push_back(16'hFFFF);
			need = need - 18'd510;
		end
		if (need > 18'd255) begin
			tx_words.push_back({8'hFF, 8'(need - 18'd255)});
		end else begin
			tx_words.push_back({8'h00, need[7:0]});
		end
	endtask

	task automatic finish_test(input string name);
		test_count++;
		if (error_count == errors_at_start) begin
			$display("Test %0d %s: passed", test_count, name);
		end else begin
			tests_failed++;
			$display("Test %0d %s: failed, %0d errors", test_count, name,
			         error_count - errors_at_start);
		end
		errors_at_start = error_count;
		cart_cycles     = 0;
		boot_cycles     = 0;
		greset_cycles   = 0;
		strobe_cycles   = 0;
	endtask

	//////////////////////////////////////////////////////////////////////
	// Tests
	//////////////////////////////////////////////////////////////////////

	task automatic test_palette_load();
		palette_t expected;
		expected = `PALETTE_DEFAULT;
		fill_random(RAND_WORDS);
		foreach (tx_words[i]) begin
			expected = {expected[`PALETTE_W-17:0], tx_words[i][7:0], tx_words[i][15:8]};
		end
		send_download(`FT_PALETTE);
		check_vec("palette", palette, expected);
		expect_true(greset_cycles > 0, "gg_reset never rose during the palette download");
		expect_true(cart_cycles == 0 && boot_cycles == 0,
		            "a cart or boot level rose during the palette download");
		finish_test("palette load");
	endtask

	task automatic test_cheat_assembly();
		logic [127:0] expected;
		fill_random(RAND_WORDS);
		// Flags, address, compare, replace, each field low word first
		expected = {tx_words[1], tx_words[0], tx_words[3], tx_words[2],
		            tx_words[5], tx_words[4], tx_words[7], tx_words[6]};
		send_download(`FT_CHEAT);
		check_vec("gg_code", gg_code, expected);
		expect_true(strobe_cycles == 1, "gg_strobe did not pulse exactly once");
		expect_true(greset_cycles == 1, "gg_reset did not pulse exactly once at address 0");
		finish_test("cheat assembly");
	endtask

	task automatic test_cgb_checksum();
		is_gbc = 1'b1;
		// Eight random words sum to far less than either known value
		fill_random(RAND_WORDS);
		send_download(`FT_CGB_BOOT);
		check_boot_flags(1'b0, 1'b0, 1'b0);
		build_padded_image(`CGB_BOOT_SUM_ORIGINAL);
		send_download(`FT_CGB_BOOT);
		check_boot_flags(1'b0, 1'b1, 1'b1);
		build_padded_image(`CGB_BOOT_SUM_MISTER);
		send_download(`FT_CGB_BOOT);
		check_boot_flags(1'b1, 1'b1, 1'b0);
		expect_true(boot_cycles > 0, "boot_download stayed low during the colour boot downloads");
		finish_test("colour boot checksum");
	endtask

	task automatic test_dmg_and_cart();
		fill_random(RAND_WORDS);
		send_download(`FT_CART_ALT);
		expect_true(cart_cycles > 0, "cart_download stayed low during the cart download");
		expect_true(boot_cycles == 0, "boot_download rose during the cart download");
		is_gbc = 1'b0;
		fill_random(RAND_WORDS);
		send_download(`FT_DMG_BOOT);
		check_bit("fastboot_available", fastboot_available, 1'b0);
		expect_true(boot_cycles > 0, "boot_download stayed low during the DMG boot download");
		reset_req = 1'b1;
		repeat (3) @(negedge clk_sys);
		reset_req = 1'b0;
		@(negedge clk_sys);
		check_boot_flags(1'b1, 1'b1, 1'b0);
		finish_test("DMG boot and cart level");
	endtask

	initial begin
		ioctl_download = 1'b0;
		ioctl_wr       = 1'b0;
		ioctl_addr     = '0;
		ioctl_dout     = '0;
		filetype       = '0;
		is_gbc         = 1'b1;
		reset_req      = 1'b0;
		lfsr_state     = 32'hc821;
		wait (reset === 1'b0);
		@(negedge clk_sys);

		check_vec("palette", palette, `PALETTE_DEFAULT);
		check_vec("gg_code", gg_code, '0);
		check_bit("gg_strobe", gg_strobe, 1'b0);
		check_bit("gg_reset", gg_reset, 1'b0);
		check_boot_flags(1'b1, 1'b1, 1'b0);
		finish_test("reset defaults");

		test_palette_load();
		test_cheat_assembly();
		test_cgb_checksum();
		test_dmg_and_cart();

		$display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
		         test_count, tests_failed, check_count, error_count);
		if (error_count == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

	// Watchdog
	initial begin
		while (cycle_count < CYCLE_LIMIT) begin
			@(posedge clk_sys);
			cycle_count++;
		end
		$display("Timeout: run went past %0d cycles", CYCLE_LIMIT);
		$display("Done: errors found");
		$finish;
	end

endmodule

// ==== tb.f ====
+incdir+.
gb_dl_pkg.sv
dl_classify.sv
boot_check.sv
config_capture.sv
gb_dl_top.sv
tb_clock.sv
tb_gb_dl.sv

// ==== Makefile ====
# Verilator flow for the download front end testbench

TOP = tb_gb_dl

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --assert --timing --top-module $(TOP) -f tb.f

sim:
	verilator --binary --assert --timing --top-module $(TOP) -f tb.f
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	@if grep -q "Done: errors found" sim.log; then echo "Simulation failed"; exit 1; fi
	@grep -q "Done: no errors" sim.log

clean:
	rm -rf obj_dir sim.log
